//--- source/rs_pkg.sv
package rs_pkg;

    localparam int RS_SIZE        = 8;
    localparam int DISPATCH_WIDTH = 2;
    localparam int CDB_WIDTH      = 2;
    localparam int NUM_ALU        = 2;
    localparam int NUM_MULT       = 1;
    localparam int DATA_WIDTH     = 16;
    localparam int PRN_WIDTH      = 5;
    localparam int ROB_WIDTH      = 4;
    localparam int COUNT_WIDTH    = 4;

    typedef logic [COUNT_WIDTH-1:0] count_t;

    typedef enum logic {FU_ALU, FU_MULT} fu_class_t;

    // MUL only travels with the multiplier class
    typedef enum logic [1:0] {ADD, SUB, AND, MUL} alu_func_t;

    // Value when ready, awaited tag in the low bits otherwise
    typedef struct packed {
        logic                  ready;
        logic [DATA_WIDTH-1:0] value;
    } operand_t;

    typedef struct packed {
        logic                 valid;
        fu_class_t            fu;
        alu_func_t            func;
        operand_t             op1;
        operand_t             op2;
        logic [ROB_WIDTH-1:0] robn;
    } rs_entry_t;

    typedef rs_entry_t dispatch_t;

    typedef struct packed {
        logic                  valid;
        logic [PRN_WIDTH-1:0]  tag;
        logic [DATA_WIDTH-1:0] value;
    } cdb_t;

    typedef struct packed {
        logic                  valid;
        alu_func_t             func;
        logic [DATA_WIDTH-1:0] op1;
        logic [DATA_WIDTH-1:0] op2;
        logic [ROB_WIDTH-1:0]  robn;
    } issue_t;

endpackage

//--- source/rs_view_if.sv
`timescale 1ns/1ps

interface rs_view_if;

    // Current slot contents as seen by the issue side
    rs_pkg::rs_entry_t [rs_pkg::RS_SIZE-1:0] slots;

    // Valid slots with both operands in hand, split by unit class
    logic [rs_pkg::RS_SIZE-1:0] alu_ready;
    logic [rs_pkg::RS_SIZE-1:0] mult_ready;

    // Slots issued this cycle, freed at the next edge
    logic [rs_pkg::RS_SIZE-1:0] clear;

    modport storage (
        output slots,
        output alu_ready,
        output mult_ready,
        input  clear
    );

    modport combine (
        input  slots,
        input  alu_ready,
        input  mult_ready,
        output clear
    );

endinterface

//--- source/rs_entries.sv
`timescale 1ns/1ps

module rs_entries (
    input  logic              clock,
    input  logic              reset,
    input  rs_pkg::dispatch_t dispatch [rs_pkg::DISPATCH_WIDTH],
    input  rs_pkg::cdb_t      cdb [rs_pkg::CDB_WIDTH],
    rs_view_if.storage        view,
    output logic              almost_full
);

    rs_pkg::rs_entry_t [rs_pkg::RS_SIZE-1:0] entries;
    rs_pkg::rs_entry_t [rs_pkg::RS_SIZE-1:0] entries_next;

    rs_pkg::count_t count;
    rs_pkg::count_t count_next;
    rs_pkg::count_t dispatch_count;

    logic [rs_pkg::RS_SIZE-1:0]        valid_mask;
    logic [rs_pkg::DISPATCH_WIDTH-1:0] dispatch_valid;

    // Capture a broadcast value into an operand still waiting on its tag
    function automatic rs_pkg::operand_t wake(rs_pkg::operand_t op);
        rs_pkg::operand_t result;
        result = op;
        for (int c = 0; c < rs_pkg::CDB_WIDTH; c++) begin
            if (!op.ready && cdb[c].valid &&
                cdb[c].tag == op.value[rs_pkg::PRN_WIDTH-1:0]) begin
                result.ready = 1'b1;
                result.value = cdb[c].value;
            end
        end
        return result;
    endfunction

    always_comb begin
        for (int s = 0; s < rs_pkg::RS_SIZE; s++) begin
            valid_mask[s] = entries[s].valid;
            view.alu_ready[s] = entries[s].valid && entries[s].op1.ready &&
                                entries[s].op2.ready && entries[s].fu == rs_pkg::FU_ALU;
            view.mult_ready[s] = entries[s].valid && entries[s].op1.ready &&
                                 entries[s].op2.ready && entries[s].fu == rs_pkg::FU_MULT;
        end
        for (int l = 0; l < rs_pkg::DISPATCH_WIDTH; l++) begin
            dispatch_valid[l] = dispatch[l].valid;
        end
    end

    assign view.slots = entries;

    always_comb begin
        logic [rs_pkg::RS_SIZE-1:0] open_slots;
        logic                       placed;
        open_slots     = ~valid_mask;
        entries_next   = entries;
        dispatch_count = '0;

        for (int s = 0; s < rs_pkg::RS_SIZE; s++) begin
            if (view.clear[s]) begin
                entries_next[s].valid = 1'b0;
            end
        end

        // Lanes in order take the lowest free slots
        for (int l = 0; l < rs_pkg::DISPATCH_WIDTH; l++) begin
            placed = 1'b0;
            if (dispatch[l].valid) begin
                for (int s = 0; s < rs_pkg::RS_SIZE; s++) begin
                    if (open_slots[s] && !placed) begin
                        entries_next[s] = dispatch[l];
                        open_slots[s]   = 1'b0;
                        placed          = 1'b1;
                    end
                end
                dispatch_count = dispatch_count + 1'b1;
            end
        end

        // Wakeup after allocation so a same-edge broadcast is not lost
        for (int s = 0; s < rs_pkg::RS_SIZE; s++) begin
            entries_next[s].op1 = wake(entries_next[s].op1);
            entries_next[s].op2 = wake(entries_next[s].op2);
        end
    end

    assign count_next = count + dispatch_count - rs_pkg::count_t'($countones(view.clear));

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int s = 0; s < rs_pkg::RS_SIZE; s++) begin
                entries[s].valid <= 1'b0;
            end
            count       <= '0;
            almost_full <= 1'b0;
        end else begin
            entries     <= entries_next;
            count       <= count_next;
            almost_full <= count_next >
                           rs_pkg::count_t'(rs_pkg::RS_SIZE - rs_pkg::DISPATCH_WIDTH);
        end
    end

    // Dispatcher must hold off on almost_full
    assert property (@(posedge clock) disable iff (reset)
        $countones(dispatch_valid) <= $countones(~valid_mask))
        else $error("rs_entries: dispatch with too few free slots");

    // Issue side may only free occupied slots
    assert property (@(posedge clock) disable iff (reset)
        (view.clear & ~valid_mask) == '0)
        else $error("rs_entries: clear names an empty slot");

endmodule

//--- source/psel_gen.sv
`timescale 1ns/1ps

module psel_gen #(
    parameter int WIDTH = rs_pkg::RS_SIZE,
    parameter int REQS  = rs_pkg::NUM_ALU
) (
    input  logic [WIDTH-1:0]           req,
    output logic [REQS-1:0][WIDTH-1:0] gnt_bus
);

    always_comb begin
        logic [WIDTH-1:0] left;
        logic             found;
        int               slot;
        left    = req;
        gnt_bus = '0;
        for (int g = 0; g < REQS; g++) begin
            found = 1'b0;
            for (int k = 0; k < WIDTH; k++) begin
                // Even grants scan upward, odd grants downward
                slot = (g % 2 == 0) ? k : WIDTH - 1 - k;
                if (left[slot] && !found) begin
                    gnt_bus[g][slot] = 1'b1;
                    found            = 1'b1;
                end
            end
            left = left & ~gnt_bus[g];
        end
    end

    always_comb begin
        logic [WIDTH-1:0] seen;
        seen = '0;
        for (int g = 0; g < REQS; g++) begin
            assert ($onehot0(gnt_bus[g]) && (gnt_bus[g] & seen) == '0 &&
                    (gnt_bus[g] & ~req) == '0)
                else $error("psel_gen: grant %0d overlaps or is not one-hot", g);
            seen = seen | gnt_bus[g];
        end
    end

endmodule

//--- source/issue_mux.sv
`timescale 1ns/1ps

module issue_mux (
    rs_view_if.combine                                           view,
    input  logic [rs_pkg::NUM_ALU-1:0][rs_pkg::RS_SIZE-1:0]      alu_gnt,
    input  logic [rs_pkg::NUM_MULT-1:0][rs_pkg::RS_SIZE-1:0]     mult_gnt,
    input  logic [rs_pkg::NUM_ALU-1:0]                           alu_avail,
    input  logic [rs_pkg::NUM_MULT-1:0]                          mult_avail,
    output rs_pkg::issue_t [rs_pkg::NUM_ALU-1:0]                 alu_issue,
    output rs_pkg::issue_t [rs_pkg::NUM_MULT-1:0]                mult_issue
);

    logic [rs_pkg::NUM_ALU-1:0][rs_pkg::RS_SIZE-1:0]  alu_sel;
    logic [rs_pkg::NUM_MULT-1:0][rs_pkg::RS_SIZE-1:0] mult_sel;

    // Fields of the selected slot, all zero when nothing is selected
    function automatic rs_pkg::issue_t pick(
        input rs_pkg::rs_entry_t [rs_pkg::RS_SIZE-1:0] slots,
        input logic [rs_pkg::RS_SIZE-1:0]              sel
    );
        rs_pkg::issue_t pkt;
        pkt = '0;
        for (int s = 0; s < rs_pkg::RS_SIZE; s++) begin
            if (sel[s]) begin
                pkt.valid = 1'b1;
                pkt.func  = slots[s].func;
                pkt.op1   = slots[s].op1.value;
                pkt.op2   = slots[s].op2.value;
                pkt.robn  = slots[s].robn;
            end
        end
        return pkt;
    endfunction

    always_comb begin
        view.clear = '0;
        for (int p = 0; p < rs_pkg::NUM_ALU; p++) begin
            // A busy unit leaves its grant standing for a later cycle
            alu_sel[p]   = alu_gnt[p] & {rs_pkg::RS_SIZE{alu_avail[p]}};
            alu_issue[p] = pick(view.slots, alu_sel[p]);
            view.clear   = view.clear | alu_sel[p];
        end
        for (int p = 0; p < rs_pkg::NUM_MULT; p++) begin
            mult_sel[p]   = mult_gnt[p] & {rs_pkg::RS_SIZE{mult_avail[p]}};
            mult_issue[p] = pick(view.slots, mult_sel[p]);
            view.clear    = view.clear | mult_sel[p];
        end
    end

    always_comb begin
        for (int p = 0; p < rs_pkg::NUM_ALU; p++) begin
            if (alu_issue[p].valid) begin
                assert ((alu_sel[p] & ~view.alu_ready) == '0)
                    else $error("issue_mux: ALU port %0d issues an unready slot", p);
            end
        end
        for (int p = 0; p < rs_pkg::NUM_MULT; p++) begin
            if (mult_issue[p].valid) begin
                assert ((mult_sel[p] & ~view.mult_ready) == '0)
                    else $error("issue_mux: MULT port %0d issues an unready slot", p);
            end
        end
    end

endmodule

//--- source/rs_issue.sv
`timescale 1ns/1ps

module rs_issue (
    input  logic                                                       clock,
    input  logic                                                       reset,
    input  logic [rs_pkg::DISPATCH_WIDTH-1:0]                          dispatch_valid,
    input  logic [rs_pkg::DISPATCH_WIDTH-1:0]                          dispatch_fu,
    input  logic [rs_pkg::DISPATCH_WIDTH-1:0][1:0]                     dispatch_func,
    input  logic [rs_pkg::DISPATCH_WIDTH-1:0]                          dispatch_op1_ready,
    input  logic [rs_pkg::DISPATCH_WIDTH-1:0]                          dispatch_op2_ready,
    input  logic [rs_pkg::DISPATCH_WIDTH-1:0][rs_pkg::DATA_WIDTH-1:0]  dispatch_op1,
    input  logic [rs_pkg::DISPATCH_WIDTH-1:0][rs_pkg::DATA_WIDTH-1:0]  dispatch_op2,
    input  logic [rs_pkg::DISPATCH_WIDTH-1:0][rs_pkg::ROB_WIDTH-1:0]   dispatch_robn,
    input  logic [rs_pkg::CDB_WIDTH-1:0]                               cdb_valid,
    input  logic [rs_pkg::CDB_WIDTH-1:0][rs_pkg::PRN_WIDTH-1:0]        cdb_tag,
    input  logic [rs_pkg::CDB_WIDTH-1:0][rs_pkg::DATA_WIDTH-1:0]       cdb_value,
    input  logic [rs_pkg::NUM_ALU-1:0]                                 alu_avail,
    input  logic [rs_pkg::NUM_MULT-1:0]                                mult_avail,
    output logic [rs_pkg::NUM_ALU-1:0]                                 alu_issue_valid,
    output logic [rs_pkg::NUM_ALU-1:0][1:0]                            alu_issue_func,
    output logic [rs_pkg::NUM_ALU-1:0][rs_pkg::DATA_WIDTH-1:0]         alu_issue_op1,
    output logic [rs_pkg::NUM_ALU-1:0][rs_pkg::DATA_WIDTH-1:0]         alu_issue_op2,
    output logic [rs_pkg::NUM_ALU-1:0][rs_pkg::ROB_WIDTH-1:0]          alu_issue_robn,
    output logic [rs_pkg::NUM_MULT-1:0]                                mult_issue_valid,
    output logic [rs_pkg::NUM_MULT-1:0][rs_pkg::DATA_WIDTH-1:0]        mult_issue_op1,
    output logic [rs_pkg::NUM_MULT-1:0][rs_pkg::DATA_WIDTH-1:0]        mult_issue_op2,
    output logic [rs_pkg::NUM_MULT-1:0][rs_pkg::ROB_WIDTH-1:0]         mult_issue_robn,
    output logic                                                       almost_full
);

    rs_pkg::dispatch_t dispatch [rs_pkg::DISPATCH_WIDTH];
    rs_pkg::cdb_t      cdb [rs_pkg::CDB_WIDTH];

    logic [rs_pkg::NUM_ALU-1:0][rs_pkg::RS_SIZE-1:0]  alu_gnt;
    logic [rs_pkg::NUM_MULT-1:0][rs_pkg::RS_SIZE-1:0] mult_gnt;

    rs_pkg::issue_t [rs_pkg::NUM_ALU-1:0]  alu_issue;
    rs_pkg::issue_t [rs_pkg::NUM_MULT-1:0] mult_issue;

    rs_view_if view ();

    always_comb begin
        for (int l = 0; l < rs_pkg::DISPATCH_WIDTH; l++) begin
            dispatch[l].valid     = dispatch_valid[l];
            dispatch[l].fu        = rs_pkg::fu_class_t'(dispatch_fu[l]);
            dispatch[l].func      = rs_pkg::alu_func_t'(dispatch_func[l]);
            dispatch[l].op1.ready = dispatch_op1_ready[l];
            dispatch[l].op1.value = dispatch_op1[l];
            dispatch[l].op2.ready = dispatch_op2_ready[l];
            dispatch[l].op2.value = dispatch_op2[l];
            dispatch[l].robn      = dispatch_robn[l];
        end
        for (int c = 0; c < rs_pkg::CDB_WIDTH; c++) begin
            cdb[c].valid = cdb_valid[c];
            cdb[c].tag   = cdb_tag[c];
            cdb[c].value = cdb_value[c];
        end
    end

    rs_entries i_rs_entries (
        .clock       (clock),
        .reset       (reset),
        .dispatch    (dispatch),
        .cdb         (cdb),
        .view        (view.storage),
        .almost_full (almost_full)
    );

    psel_gen #(
        .WIDTH (rs_pkg::RS_SIZE),
        .REQS  (rs_pkg::NUM_ALU)
    ) i_alu_sel (
        .req     (view.alu_ready),
        .gnt_bus (alu_gnt)
    );

    psel_gen #(
        .WIDTH (rs_pkg::RS_SIZE),
        .REQS  (rs_pkg::NUM_MULT)
    ) i_mult_sel (
        .req     (view.mult_ready),
        .gnt_bus (mult_gnt)
    );

    issue_mux i_issue_mux (
        .view       (view.combine),
        .alu_gnt    (alu_gnt),
        .mult_gnt   (mult_gnt),
        .alu_avail  (alu_avail),
        .mult_avail (mult_avail),
        .alu_issue  (alu_issue),
        .mult_issue (mult_issue)
    );

    always_comb begin
        for (int p = 0; p < rs_pkg::NUM_ALU; p++) begin
            alu_issue_valid[p] = alu_issue[p].valid;
            alu_issue_func[p]  = alu_issue[p].func;
            alu_issue_op1[p]   = alu_issue[p].op1;
            alu_issue_op2[p]   = alu_issue[p].op2;
            alu_issue_robn[p]  = alu_issue[p].robn;
        end
        for (int p = 0; p < rs_pkg::NUM_MULT; p++) begin
            mult_issue_valid[p] = mult_issue[p].valid;
            mult_issue_op1[p]   = mult_issue[p].op1;
            mult_issue_op2[p]   = mult_issue[p].op2;
            mult_issue_robn[p]  = mult_issue[p].robn;
        end
    end

endmodule

//--- verification/rs_issue_tb.sv
`timescale 1ns/1ps

module rs_issue_tb;

    localparam int NUM_ROWS     = 29;
    localparam int RESET_CYCLES = 3;
    localparam int CYCLE_LIMIT  = NUM_ROWS + RESET_CYCLES + 20;

    // One cycle of stimulus and the outputs expected during that cycle
    typedef struct packed {
        logic [1:0]       d_valid;
        logic [1:0]       d_fu;
        logic [1:0][1:0]  d_func;
        logic [1:0]       d_r1;
        logic [1:0]       d_r2;
        logic [1:0][15:0] d_op1;
        logic [1:0][15:0] d_op2;
        logic [1:0][3:0]  d_robn;
        logic [1:0]       c_valid;
        logic [1:0][4:0]  c_tag;
        logic [1:0][15:0] c_value;
        logic [1:0]       alu_avail;
        logic             mult_avail;
        logic [1:0]       e_alu_valid;
        logic [1:0][1:0]  e_alu_func;
        logic [1:0][3:0]  e_alu_robn;
        logic [1:0][15:0] e_alu_op1;
        logic [1:0][15:0] e_alu_op2;
        logic             e_mult_valid;
        logic [3:0]       e_mult_robn;
        logic [15:0]      e_mult_op1;
        logic [15:0]      e_mult_op2;
        logic             e_almost_full;
    } row_t;

    logic             clock;
    logic             reset;
    logic [1:0]       dispatch_valid;
    logic [1:0]       dispatch_fu;
    logic [1:0][1:0]  dispatch_func;
    logic [1:0]       dispatch_op1_ready;
    logic [1:0]       dispatch_op2_ready;
    logic [1:0][15:0] dispatch_op1;
    logic [1:0][15:0] dispatch_op2;
    logic [1:0][3:0]  dispatch_robn;
    logic [1:0]       cdb_valid;
    logic [1:0][4:0]  cdb_tag;
    logic [1:0][15:0] cdb_value;
    logic [1:0]       alu_avail;
    logic [0:0]       mult_avail;
    logic [1:0]       alu_issue_valid;
    logic [1:0][1:0]  alu_issue_func;
    logic [1:0][15:0] alu_issue_op1;
    logic [1:0][15:0] alu_issue_op2;
    logic [1:0][3:0]  alu_issue_robn;
    logic [0:0]       mult_issue_valid;
    logic [0:0][15:0] mult_issue_op1;
    logic [0:0][15:0] mult_issue_op2;
    logic [0:0][3:0]  mult_issue_robn;
    logic             almost_full;

    row_t        rows [NUM_ROWS];
    logic [15:0] op1_of [16];
    logic [15:0] op2_of [16];
    logic [1:0]  func_of [16];
    logic [31:0] lfsr = 32'hf583;
    int          cycles = 0;

    rs_issue i_rs_issue (.*);

    initial begin
        clock = 1'b0;
        forever #2 clock = ~clock;
    end

    always @(posedge clock) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("Timeout: the run went past %0d clock cycles", CYCLE_LIMIT);
            $display("Verification failed");
            $fatal(1, "stopping on timeout");
        end
    end

    // Fibonacci LFSR, taps 32 22 2 1
    function automatic logic next_bit();
        logic fb;
        fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
        lfsr = {lfsr[30:0], fb};
        return fb;
    endfunction

    function automatic logic [15:0] random_word();
        logic [15:0] w;
        w = '0;
        for (int i = 0; i < 16; i++) begin
            w = {w[14:0], next_bit()};
        end
        return w;
    endfunction

    task automatic load_ready(input int r, input int lane, input logic fu,
                              input logic [1:0] func, input logic [3:0] robn);
        rows[r].d_valid[lane] = 1'b1;
        rows[r].d_fu[lane]    = fu;
        rows[r].d_func[lane]  = func;
        rows[r].d_r1[lane]    = 1'b1;
        rows[r].d_r2[lane]    = 1'b1;
        rows[r].d_op1[lane]   = random_word();
        rows[r].d_op2[lane]   = random_word();
        rows[r].d_robn[lane]  = robn;
        op1_of[robn]  = rows[r].d_op1[lane];
        op2_of[robn]  = rows[r].d_op2[lane];
        func_of[robn] = func;
    endtask

    // ALU op on lane 0 with one operand awaiting a tag
    task automatic load_waiting(input int r, input logic [3:0] robn, input int which,
                                input logic [4:0] tag, input logic [15:0] value);
        load_ready(r, 0, rs_pkg::FU_ALU, rs_pkg::ADD, robn);
        if (which == 1) begin
            rows[r].d_r1[0]  = 1'b0;
            rows[r].d_op1[0] = 16'(tag);
            op1_of[robn]     = value;
        end else begin
            rows[r].d_r2[0]  = 1'b0;
            rows[r].d_op2[0] = 16'(tag);
            op2_of[robn]     = value;
        end
    endtask

    task automatic broadcast(input int r, input int lane, input logic [4:0] tag,
                             input logic [15:0] value);
        rows[r].c_valid[lane] = 1'b1;
        rows[r].c_tag[lane]   = tag;
        rows[r].c_value[lane] = value;
    endtask

    task automatic want_alu(input int r, input int port, input logic [3:0] robn);
        rows[r].e_alu_valid[port] = 1'b1;
        rows[r].e_alu_func[port]  = func_of[robn];
        rows[r].e_alu_robn[port]  = robn;
        rows[r].e_alu_op1[port]   = op1_of[robn];
        rows[r].e_alu_op2[port]   = op2_of[robn];
    endtask

    task automatic want_mult(input int r, input logic [3:0] robn);
        rows[r].e_mult_valid = 1'b1;
        rows[r].e_mult_robn  = robn;
        rows[r].e_mult_op1   = op1_of[robn];
        rows[r].e_mult_op2   = op2_of[robn];
    endtask

    task automatic build_table();
        for (int r = 0; r < NUM_ROWS; r++) begin
            rows[r]            = '0;
            rows[r].alu_avail  = 2'b11;
            rows[r].mult_avail = 1'b1;
        end
        // Single issue after reset, then silence
        load_ready(1, 0, rs_pkg::FU_ALU, rs_pkg::ADD, 4'd1);
        want_alu(2, 0, 4'd1);
        // Two ALU ops together, multiplier in the next row
        load_ready(4, 0, rs_pkg::FU_ALU, rs_pkg::SUB, 4'd2);
        load_ready(4, 1, rs_pkg::FU_ALU, rs_pkg::AND, 4'd3);
        want_alu(5, 0, 4'd2);
        want_alu(5, 1, 4'd3);
        load_ready(5, 0, rs_pkg::FU_MULT, rs_pkg::MUL, 4'd4);
        want_mult(6, 4'd4);
        // Wakeup by a later broadcast and on the writing edge
        load_waiting(7, 4'd5, 1, 5'd9, random_word());
        broadcast(9, 0, 5'd9, op1_of[5]);
        want_alu(10, 0, 4'd5);
        load_waiting(11, 4'd6, 2, 5'd17, random_word());
        broadcast(11, 1, 5'd17, op2_of[6]);
        want_alu(12, 0, 4'd6);
        // Multiplier busy for three rows
        load_ready(13, 0, rs_pkg::FU_MULT, rs_pkg::MUL, 4'd7);
        for (int r = 13; r <= 15; r++) begin
            rows[r].mult_avail = 1'b0;
        end
        want_mult(16, 4'd7);
        // Port 0 busy while port 1 issues
        load_ready(17, 0, rs_pkg::FU_ALU, rs_pkg::ADD, 4'd8);
        load_ready(17, 1, rs_pkg::FU_ALU, rs_pkg::SUB, 4'd9);
        rows[18].alu_avail = 2'b10;
        want_alu(18, 1, 4'd9);
        want_alu(19, 0, 4'd8);
        // Fill to seven slots with every unit busy
        for (int r = 20; r <= 24; r++) begin
            rows[r].alu_avail  = 2'b00;
            rows[r].mult_avail = 1'b0;
        end
        load_ready(20, 0, rs_pkg::FU_ALU, rs_pkg::ADD, 4'd10);
        load_ready(20, 1, rs_pkg::FU_ALU, rs_pkg::ADD, 4'd11);
        load_ready(21, 0, rs_pkg::FU_ALU, rs_pkg::SUB, 4'd12);
        load_ready(21, 1, rs_pkg::FU_ALU, rs_pkg::AND, 4'd13);
        load_ready(22, 0, rs_pkg::FU_MULT, rs_pkg::MUL, 4'd14);
        load_ready(22, 1, rs_pkg::FU_MULT, rs_pkg::MUL, 4'd15);
        load_ready(23, 0, rs_pkg::FU_ALU, rs_pkg::ADD, 4'd0);
        rows[24].e_almost_full = 1'b1;
        rows[25].e_almost_full = 1'b1;
        // Drain: lowest and highest ALU slots first
        want_alu(25, 0, 4'd10);
        want_alu(25, 1, 4'd0);
        want_mult(25, 4'd14);
        want_alu(26, 0, 4'd11);
        want_alu(26, 1, 4'd13);
        want_mult(26, 4'd15);
        want_alu(27, 0, 4'd12);
    endtask

    task automatic apply_row(input row_t row);
        dispatch_valid     = row.d_valid;
        dispatch_fu        = row.d_fu;
        dispatch_func      = row.d_func;
        dispatch_op1_ready = row.d_r1;
        dispatch_op2_ready = row.d_r2;
        dispatch_op1       = row.d_op1;
        dispatch_op2       = row.d_op2;
        dispatch_robn      = row.d_robn;
        cdb_valid          = row.c_valid;
        cdb_tag            = row.c_tag;
        cdb_value          = row.c_value;
        alu_avail          = row.alu_avail;
        mult_avail         = row.mult_avail;
    endtask

    task automatic check_field(input string name, input int r,
                               input logic [15:0] expected, input logic [15:0] actual);
        assert (actual === expected)
            else begin
                $display("FAILED at %0t ns, row %0d: %s expected %h, actual %h",
                         $time, r, name, expected, actual);
                $display("Verification failed");
                $fatal(1, "stopping at the first mismatch");
            end
    endtask

    task automatic check_row(input int r);
        row_t e;
        e = rows[r];
        check_field("almost_full", r, 16'(e.e_almost_full), 16'(almost_full));
        for (int p = 0; p < 2; p++) begin
            check_field($sformatf("alu_issue_valid[%0d]", p), r,
                        16'(e.e_alu_valid[p]), 16'(alu_issue_valid[p]));
            if (e.e_alu_valid[p]) begin
                check_field($sformatf("alu_issue_func[%0d]", p), r,
                            16'(e.e_alu_func[p]), 16'(alu_issue_func[p]));
                check_field($sformatf("alu_issue_robn[%0d]", p), r,
                            16'(e.e_alu_robn[p]), 16'(alu_issue_robn[p]));
                check_field($sformatf("alu_issue_op1[%0d]", p), r,
                            e.e_alu_op1[p], alu_issue_op1[p]);
                check_field($sformatf("alu_issue_op2[%0d]", p), r,
                            e.e_alu_op2[p], alu_issue_op2[p]);
            end
        end
        check_field("mult_issue_valid", r, 16'(e.e_mult_valid), 16'(mult_issue_valid[0]));
        if (e.e_mult_valid) begin
            check_field("mult_issue_robn", r, 16'(e.e_mult_robn), 16'(mult_issue_robn[0]));
            check_field("mult_issue_op1", r, e.e_mult_op1, mult_issue_op1[0]);
            check_field("mult_issue_op2", r, e.e_mult_op2, mult_issue_op2[0]);
        end
    endtask

    initial begin
        reset = 1'b1;
        apply_row('0);
        build_table();
        repeat (RESET_CYCLES) @(posedge clock);
        for (int r = 0; r < NUM_ROWS; r++) begin
            @(negedge clock);
            reset = 1'b0;
            apply_row(rows[r]);
            // Sample one ns before the rising edge
            #1;
            check_row(r);
        end
        $display("Verification passed");
        $finish;
    end

endmodule

//--- flist.f
source/rs_pkg.sv
source/rs_view_if.sv
source/rs_entries.sv
source/psel_gen.sv
source/issue_mux.sv
source/rs_issue.sv
verification/rs_issue_tb.sv

//--- Makefile
VERILATOR = verilator
FLAGS     = --binary --assert -j 0
TOP       = rs_issue_tb
FILELIST  = flist.f
BUILD_DIR = obj_dir
PASS_TEXT = Verification passed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)
